// File: bench/l2_cases.txt
// Fields: op (0 read, 1 write) _ address _ strobe _ write data _ expected read data
// Expected data is only compared on in-range reads
1_00000004_f_12345678_00000000
0_00000004_0_00000000_12345678
1_00000004_5_aabbccdd_00000000
0_00000004_0_00000000_12bb56dd
1_00000004_8_ee000000_00000000
0_00000004_0_00000000_eebb56dd
1_00000008_f_0badf00d_00000000
1_00000008_2_0000a500_00000000
0_00000008_0_00000000_0bada50d
1_00000010_f_11111111_00000000
1_00000110_f_22222222_00000000
1_00000210_f_33333333_00000000
1_00000310_f_44444444_00000000
1_00000410_f_55555555_00000000
0_00000010_0_00000000_11111111
0_00000110_0_00000000_22222222
0_00000210_0_00000000_33333333
0_00000310_0_00000000_44444444
0_00000410_0_00000000_55555555
1_00001004_f_ffffffff_00000000
0_00001004_0_00000000_00000000
0_00000004_0_00000000_eebb56dd

// File: build.f
+incdir+rtl
rtl/l2_pkg.sv
rtl/bram_bytewrite.sv
rtl/l2_data_array.sv
rtl/l2_tag_array.sv
rtl/l2_backing_mem.sv
rtl/l2_ctrl.sv
rtl/l2_cache.sv
bench/l2_checker.sv
bench/tb_l2_cache.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/l2_pkg.sv
      - rtl/bram_bytewrite.sv
      - rtl/l2_data_array.sv
      - rtl/l2_tag_array.sv
      - rtl/l2_backing_mem.sv
      - rtl/l2_ctrl.sv
      - rtl/l2_cache.sv
  - target: test
    files:
      - bench/l2_checker.sv
      - bench/tb_l2_cache.sv

// File: bench/tb_l2_cache.sv
module tb_l2_cache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cases   = 64;
    localparam int random_ops  = 300;
    localparam int ready_limit = 250;

    logic         clk;
    logic         rst_n;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [31:0]  paddr;
    logic [31:0]  pwdata;
    logic [3:0]   pstrb;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;

    logic         exp_en;
    logic [31:0]  exp_data;
    int           errors;
    int           timeouts;
    logic         aborted;

    // Case entry is op, address, strobe, write data, expected read data
    logic [103:0] cases [max_cases];
    logic [31:0]  rnd_state;

    l2_cache DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    l2_checker u_checker (
        .clk      (clk),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .exp_en   (exp_en),
        .exp_data (exp_data),
        .errors   (errors),
        .timeouts (timeouts)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////
    // APB master
    ////////////////////////////////////////

    // Setup cycle, then access cycles until pready or the limit
    task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data, input logic check,
                                input logic [31:0] exp_word);
        int waited;
        waited   = 0;
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= wr;
        paddr    <= addr;
        pwdata   <= data;
        pstrb    <= wr ? strb : 4'h0;
        exp_en   <= check;
        exp_data <= exp_word;
        @(posedge clk);
        penable <= 1'b1;
        // pready is looked at mid cycle, away from the clock edge
        @(negedge clk);
        while (pready !== 1'b1 && waited < ready_limit) begin
            @(negedge clk);
            waited++;
        end
        if (pready !== 1'b1) begin
            $display("Transfer to address %h never completed, run stopped", addr);
            aborted = 1'b1;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        exp_en  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_cases();
        int           n;
        logic [103:0] c;
        n = 0;
        while (n < max_cases && !$isunknown(cases[n]) && !aborted) begin
            c = cases[n];
            apb_transfer(c[103:100] == 4'h1, c[99:68], c[67:64], c[63:32],
                         c[103:100] == 4'h0, c[31:0]);
            n++;
        end
        if (n == 0) begin
            $display("No cases could be read from bench/l2_cases.txt");
            aborted = 1'b1;
        end
    endtask

    // Word aligned addresses anywhere in the 4 KiB range
    task automatic run_random();
        logic [31:0] r;
        for (int i = 0; i < random_ops && !aborted; i++) begin
            rnd_state = next_random(rnd_state);
            r         = rnd_state;
            rnd_state = next_random(rnd_state);
            apb_transfer(r[31], {20'h0, r[11:2], 2'b00}, r[15:12], rnd_state, 1'b0, 32'h0);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        exp_en    = 1'b0;
        exp_data  = '0;
        aborted   = 1'b0;
        rnd_state = 32'd17129;
        $readmemh("bench/l2_cases.txt", cases);

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // Bus stays idle for a while after reset
        repeat (3) @(posedge clk);

        run_cases();
        run_random();
        repeat (4) @(posedge clk);

        $display("Run done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0 && !aborted) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: bench/l2_checker.sv
module l2_checker (
    input  logic        clk,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic        exp_en,
    input  logic [31:0] exp_data,
    output int          errors,
    output int          timeouts
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ready_limit = 200;

    // Word model over the 4 KiB range, with the bytes written so far
    logic [31:0] model [1024];
    logic [3:0]  known [1024];
    logic [31:0] mask;
    logic        out_of_range;
    int          waited;
    int          idx;

    initial begin
        errors   = 0;
        timeouts = 0;
        waited   = 0;
        for (int i = 0; i < 1024; i++) begin
            model[i] = '0;
            known[i] = '0;
        end
    end

    // Sampled mid cycle where every APB signal is settled
    always @(negedge clk) begin
        out_of_range = |paddr[31:12];
        idx          = int'(paddr[11:2]);

        if (!(psel && penable) && (pready !== 1'b0 || pslverr !== 1'b0)) begin
            errors++;
            $display("pready or pslverr went high at %0t outside an access phase", $time);
        end

        if (psel && penable && pready !== 1'b1) begin
            waited++;
            if (waited == ready_limit) begin
                timeouts++;
                $display("No pready within %0d cycles for address %h", ready_limit, paddr);
            end
        end else begin
            waited = 0;
        end

        if (psel && penable && pready === 1'b1) begin
            if (pslverr !== out_of_range) begin
                errors++;
                $display("error pslverr at %h: got %h expected %h", paddr, pslverr, out_of_range);
            end
            if (!out_of_range && pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (pstrb[b]) begin
                        model[idx][b*8 +: 8] = pwdata[b*8 +: 8];
                        known[idx][b]        = 1'b1;
                    end
                end
            end
            if (!out_of_range && !pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    mask[b*8 +: 8] = {8{known[idx][b]}};
                end
                if ((prdata & mask) !== (model[idx] & mask)) begin
                    errors++;
                    $display("error prdata at %h: got %h expected %h under mask %h",
                             paddr, prdata, model[idx], mask);
                end
                if (exp_en && prdata !== exp_data) begin
                    errors++;
                    $display("error prdata at %h: got %h expected %h from case file",
                             paddr, prdata, exp_data);
                end
            end
        end
    end

endmodule

// File: rtl/l2_cache.sv
module l2_cache (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [31:0]    paddr,
    input  l2_pkg::word_t  pwdata,
    input  l2_pkg::strb_t  pstrb,
    output l2_pkg::word_t  prdata,
    output logic           pready,
    output logic           pslverr
);

    l2_pkg::set_idx_t    req_set;
    l2_pkg::tag_t        req_tag;
    l2_pkg::offset_t     req_offset;

    logic                tag_rd_en;
    logic                tag_wr_en;
    l2_pkg::way_oh_t     tag_wr_way;
    logic                tag_wr_dirty;
    l2_pkg::way_oh_t     hit_way;
    l2_pkg::way_oh_t     victim_way;
    l2_pkg::tag_t        victim_tag;
    logic                victim_dirty;

    l2_pkg::way_oh_t     way_we;
    logic                replace;
    l2_pkg::strb_t       wr_strb;
    l2_pkg::word_t       word_in;
    l2_pkg::line_t       line_out0;
    l2_pkg::line_t       line_out1;
    l2_pkg::line_t       line_out2;
    l2_pkg::line_t       line_out3;

    logic                mem_req;
    logic                mem_write;
    l2_pkg::line_addr_t  mem_addr;
    l2_pkg::line_t       mem_wdata;
    l2_pkg::line_t       mem_rdata;
    logic                mem_done;

    l2_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .pstrb        (pstrb),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .req_set      (req_set),
        .req_tag      (req_tag),
        .req_offset   (req_offset),
        .tag_rd_en    (tag_rd_en),
        .tag_wr_en    (tag_wr_en),
        .tag_wr_way   (tag_wr_way),
        .tag_wr_dirty (tag_wr_dirty),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .way_we       (way_we),
        .replace      (replace),
        .wr_strb      (wr_strb),
        .word_in      (word_in),
        .line_out0    (line_out0),
        .line_out1    (line_out1),
        .line_out2    (line_out2),
        .line_out3    (line_out3),
        .mem_req      (mem_req),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_done     (mem_done)
    );

    l2_tag_array u_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_en        (tag_rd_en),
        .set          (req_set),
        .lookup_tag   (req_tag),
        .wr_en        (tag_wr_en),
        .wr_way       (tag_wr_way),
        .wr_tag       (req_tag),
        .wr_dirty     (tag_wr_dirty),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    // Refill data comes straight from the backing store
    l2_data_array u_data (
        .clk       (clk),
        .rd_set    (req_set),
        .wr_set    (req_set),
        .way_we    (way_we),
        .replace   (replace),
        .offset    (req_offset),
        .strb      (wr_strb),
        .line_in   (mem_rdata),
        .word_in   (word_in),
        .line_out0 (line_out0),
        .line_out1 (line_out1),
        .line_out2 (line_out2),
        .line_out3 (line_out3)
    );

    l2_backing_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .write (mem_write),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata),
        .done  (mem_done)
    );

endmodule

// File: rtl/l2_ctrl.sv
`include "l2_params.svh"

module l2_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    // APB slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         paddr,
    input  l2_pkg::word_t       pwdata,
    input  l2_pkg::strb_t       pstrb,
    output l2_pkg::word_t       prdata,
    output logic                pready,
    output logic                pslverr,
    // Address fields, shared by both arrays
    output l2_pkg::set_idx_t    req_set,
    output l2_pkg::tag_t        req_tag,
    output l2_pkg::offset_t     req_offset,
    // Tag array
    output logic                tag_rd_en,
    output logic                tag_wr_en,
    output l2_pkg::way_oh_t     tag_wr_way,
    output logic                tag_wr_dirty,
    input  l2_pkg::way_oh_t     hit_way,
    input  l2_pkg::way_oh_t     victim_way,
    input  l2_pkg::tag_t        victim_tag,
    input  logic                victim_dirty,
    // Data array
    output l2_pkg::way_oh_t     way_we,
    output logic                replace,
    output l2_pkg::strb_t       wr_strb,
    output l2_pkg::word_t       word_in,
    input  l2_pkg::line_t       line_out0,
    input  l2_pkg::line_t       line_out1,
    input  l2_pkg::line_t       line_out2,
    input  l2_pkg::line_t       line_out3,
    // Backing store
    output logic                mem_req,
    output logic                mem_write,
    output l2_pkg::line_addr_t  mem_addr,
    output l2_pkg::line_t       mem_wdata,
    input  logic                mem_done
);

    l2_pkg::ctrl_state_t state;
    l2_pkg::ctrl_state_t next_state;

    l2_pkg::line_t lines [`L2_WAYS];
    l2_pkg::line_t hit_line;
    l2_pkg::line_t victim_line;
    logic          hit;
    logic          out_of_range;
    logic          bad_access;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign out_of_range = |paddr[31:`L2_ADDR_BITS];
    assign bad_access   = (state == l2_pkg::idle) && psel && penable && out_of_range;
    assign req_tag      = paddr[`L2_ADDR_BITS-1:6];
    assign req_set      = paddr[7:4];
    assign req_offset   = paddr[3:2];

    assign wr_strb = pstrb;
    assign word_in = pwdata;

    assign lines = '{line_out0, line_out1, line_out2, line_out3};
    assign hit   = |hit_way;

    always_comb begin
        hit_line    = '0;
        victim_line = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit_line    = hit_line | (lines[w] & {$bits(l2_pkg::line_t){hit_way[w]}});
            victim_line = victim_line | (lines[w] & {$bits(l2_pkg::line_t){victim_way[w]}});
        end
    end

    // Write-back data is taken by the store with the request
    assign mem_wdata = victim_line;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
        next_state   = state;
        tag_rd_en    = 1'b0;
        tag_wr_en    = 1'b0;
        tag_wr_way   = '0;
        tag_wr_dirty = 1'b0;
        way_we       = '0;
        replace      = 1'b0;
        mem_req      = 1'b0;
        mem_write    = 1'b0;
        mem_addr     = {req_tag, req_set};
        case (state)
            l2_pkg::idle: begin
                if (psel && penable && !out_of_range) begin
                    next_state = l2_pkg::lookup;
                end
            end
            l2_pkg::lookup: begin
                tag_rd_en  = 1'b1;
                next_state = l2_pkg::compare;
            end
            l2_pkg::compare: begin
                if (hit) begin
                    // Touch the LRU on every hit, mark dirty on a write
                    tag_wr_en    = 1'b1;
                    tag_wr_way   = hit_way;
                    tag_wr_dirty = pwrite;
                    way_we       = pwrite ? hit_way : '0;
                    next_state   = l2_pkg::finish;
                end else if (victim_dirty) begin
                    mem_req    = 1'b1;
                    mem_write  = 1'b1;
                    mem_addr   = {victim_tag, req_set};
                    next_state = l2_pkg::writeback;
                end else begin
                    mem_req    = 1'b1;
                    next_state = l2_pkg::refill;
                end
            end
            l2_pkg::writeback: begin
                if (mem_done) begin
                    mem_req    = 1'b1;
                    next_state = l2_pkg::refill;
                end
            end
            l2_pkg::refill: begin
                // New line goes in clean, then the lookup is retried
                if (mem_done) begin
                    way_we     = victim_way;
                    replace    = 1'b1;
                    tag_wr_en  = 1'b1;
                    tag_wr_way = victim_way;
                    next_state = l2_pkg::lookup;
                end
            end
            l2_pkg::finish: begin
                next_state = l2_pkg::idle;
            end
            default: begin
                next_state = l2_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= l2_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == l2_pkg::compare && hit && !pwrite) begin
            prdata <= hit_line[{req_offset, 5'b00000} +: 32];
        end
    end

    assign pready  = (state == l2_pkg::finish) || bad_access;
    assign pslverr = bad_access;

    a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable);

    // One line transfer at a time to the backing store
    a_mem_single: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> (!mem_req until mem_done));

endmodule

// File: rtl/l2_backing_mem.sv
`include "l2_params.svh"

module l2_backing_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  logic                write,
    input  l2_pkg::line_addr_t  addr,
    input  l2_pkg::line_t       wdata,
    output l2_pkg::line_t       rdata,
    output logic                done
);

    localparam int cnt_w = $clog2(`L2_MEM_DELAY + 1);

    l2_pkg::line_t       mem [2**$bits(l2_pkg::line_addr_t)];
    logic [cnt_w-1:0]    cnt;
    logic                pend_write;
    l2_pkg::line_addr_t  pend_addr;
    l2_pkg::line_t       pend_wdata;

    // Delay timer, done lands L2_MEM_DELAY cycles after req
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (req) begin
                cnt <= cnt_w'(`L2_MEM_DELAY);
            end else if (cnt != '0) begin
                cnt  <= cnt - 1'b1;
                done <= (cnt == cnt_w'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            pend_write <= write;
            pend_addr  <= addr;
            pend_wdata <= wdata;
        end
        // Access itself happens on the last edge
        if (cnt == cnt_w'(1)) begin
            if (pend_write) begin
                mem[pend_addr] <= pend_wdata;
            end else begin
                rdata <= mem[pend_addr];
            end
        end
    end

endmodule

// File: rtl/l2_tag_array.sv
`include "l2_params.svh"

module l2_tag_array (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_en,
    input  l2_pkg::set_idx_t  set,
    input  l2_pkg::tag_t      lookup_tag,
    input  logic              wr_en,
    input  l2_pkg::way_oh_t   wr_way,
    input  l2_pkg::tag_t      wr_tag,
    input  logic              wr_dirty,
    output l2_pkg::way_oh_t   hit_way,
    output l2_pkg::way_oh_t   victim_way,
    output l2_pkg::tag_t      victim_tag,
    output logic              victim_dirty
);

    localparam int way_bits = $clog2(`L2_WAYS);

    l2_pkg::tag_t         tags  [`L2_SETS][`L2_WAYS];
    logic [`L2_WAYS-1:0]  valid [`L2_SETS];
    logic [`L2_WAYS-1:0]  dirty [`L2_SETS];
    // Tree bits: [0] picks the pair, [1] the left way, [2] the right way
    logic [2:0]           plru  [`L2_SETS];

    l2_pkg::way_oh_t      hit_vec;
    logic [way_bits-1:0]  pick;
    logic [way_bits-1:0]  wr_idx;
    logic [2:0]           plru_next;
    logic                 found;
    logic                 same_line;

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit_vec[w] = valid[set][w] && (tags[set][w] == lookup_tag);
        end
    end

    // Invalid way first, else follow the tree
    always_comb begin
        found = 1'b0;
        pick  = plru[set][0] ? {1'b1, plru[set][2]} : {1'b0, plru[set][1]};
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (!valid[set][w] && !found) begin
                pick  = way_bits'(w);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        wr_idx = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (wr_way[w]) begin
                wr_idx = way_bits'(w);
            end
        end
    end

    // Point the tree away from the way just touched
    always_comb begin
        plru_next    = plru[set];
        plru_next[0] = ~wr_idx[1];
        if (wr_idx[1]) begin
            plru_next[2] = ~wr_idx[0];
        end else begin
            plru_next[1] = ~wr_idx[0];
        end
    end

    assign same_line = valid[set][wr_idx] && (tags[set][wr_idx] == wr_tag);

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                valid[s] <= '0;
                plru[s]  <= '0;
            end
            hit_way      <= '0;
            victim_way   <= '0;
            victim_dirty <= 1'b0;
        end else begin
            if (rd_en) begin
                hit_way      <= hit_vec;
                victim_way   <= l2_pkg::way_oh_t'(1) << pick;
                victim_dirty <= valid[set][pick] && dirty[set][pick];
            end
            if (wr_en) begin
                valid[set][wr_idx] <= 1'b1;
                plru[set]          <= plru_next;
            end
        end
    end

    ////////////////////////////////////////
    // Tags and dirty bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_en) begin
            victim_tag <= tags[set][pick];
        end
        if (wr_en) begin
            tags[set][wr_idx]  <= wr_tag;
            // A rewrite of the same line keeps it dirty
            dirty[set][wr_idx] <= wr_dirty || (same_line && dirty[set][wr_idx]);
        end
    end

endmodule

// File: rtl/l2_data_array.sv
`include "l2_params.svh"

module l2_data_array (
    input  logic              clk,
    input  l2_pkg::set_idx_t  rd_set,
    input  l2_pkg::set_idx_t  wr_set,
    input  l2_pkg::way_oh_t   way_we,
    input  logic              replace,
    input  l2_pkg::offset_t   offset,
    input  l2_pkg::strb_t     strb,
    input  l2_pkg::line_t     line_in,
    input  l2_pkg::word_t     word_in,
    output l2_pkg::line_t     line_out0,
    output l2_pkg::line_t     line_out1,
    output l2_pkg::line_t     line_out2,
    output l2_pkg::line_t     line_out3
);

    localparam int line_bytes = `L2_WORDS_PER_LINE * 4;

    logic [line_bytes-1:0] lane_we;
    l2_pkg::line_t         din;
    l2_pkg::line_t         dout [`L2_WAYS];

    // Whole line on refill, else one word moved to its lane
    always_comb begin
        if (replace) begin
            lane_we = '1;
            din     = line_in;
        end else begin
            lane_we = line_bytes'(strb) << {offset, 2'b00};
            din     = l2_pkg::line_t'(word_in) << {offset, 5'b00000};
        end
    end

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        bram_bytewrite #(
            .data_width ($bits(l2_pkg::line_t)),
            .addr_width ($bits(l2_pkg::set_idx_t))
        ) u_bram (
            .clk   (clk),
            .waddr (wr_set),
            .din   (din),
            .we    (way_we[w] ? lane_we : '0),
            .raddr (rd_set),
            .dout  (dout[w])
        );
    end

    assign line_out0 = dout[0];
    assign line_out1 = dout[1];
    assign line_out2 = dout[2];
    assign line_out3 = dout[3];

    // Controller never writes two ways of a set at once
    a_one_way: assert property (@(posedge clk) $isunknown(way_we) || $onehot0(way_we));

endmodule

// File: rtl/bram_bytewrite.sv
module bram_bytewrite #(
    parameter int data_width = 128,
    parameter int addr_width = 4
) (
    input  logic                    clk,
    input  logic [addr_width-1:0]   waddr,
    input  logic [data_width-1:0]   din,
    input  logic [data_width/8-1:0] we,
    input  logic [addr_width-1:0]   raddr,
    output logic [data_width-1:0]   dout
);

    logic [data_width-1:0] mem [2**addr_width];

    always_ff @(posedge clk) begin
        for (int b = 0; b < data_width / 8; b++) begin
            if (we[b]) begin
                mem[waddr][b*8 +: 8] <= din[b*8 +: 8];
            end
        end
        // Read returns the old contents on a same-address write
        dout <= mem[raddr];
    end

endmodule

// File: rtl/l2_pkg.sv
`include "l2_params.svh"

package l2_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;
    typedef logic [`L2_WORDS_PER_LINE*32-1:0] line_t;

    typedef logic [$clog2(`L2_SETS)-1:0] set_idx_t;
    typedef logic [$clog2(`L2_WORDS_PER_LINE)-1:0] offset_t;

    // Address bits 11 to 6, overlapping the top of the set index
    typedef logic [`L2_ADDR_BITS-7:0] tag_t;

    typedef logic [`L2_WAYS-1:0] way_oh_t;

    // Tag and set together name one line of the backing store
    typedef logic [$bits(tag_t)+$bits(set_idx_t)-1:0] line_addr_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        compare,
        writeback,
        refill,
        finish
    } ctrl_state_t;

endpackage

// File: rtl/l2_params.svh
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// Cache geometry
`define L2_WAYS 4
`define L2_SETS 16
`define L2_WORDS_PER_LINE 4

// Byte addresses at or above 2**L2_ADDR_BITS are out of range
`define L2_ADDR_BITS 12

// Backing store cycles per line access
`define L2_MEM_DELAY 4

`endif
